//--- logic/rvExec_settings.svh
`ifndef RVEXEC_SETTINGS_SVH
`define RVEXEC_SETTINGS_SVH

// datapath width in bits
`define XLEN 32

// architectural register count, x0 included
`define NUM_REGS 32

`endif

//--- logic/rvExecPkg.sv
`include "rvExec_settings.svh"

package rvExecPkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] regAddr_t;

    // ALU operations, branches share the compare unit
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
        OR, AND, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } aluOp_t;

    // what goes into rd
    typedef enum logic {
        ALU_RES = 1'b0,
        IMM_RES = 1'b1  // LUI
    } wbSrc_t;

    // decode -> execute
    typedef struct packed {
        logic     valid;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        aluOp_t   aluOp;
        logic     useImm;    // operand B from imm
        word_t    imm;
        wbSrc_t   wbSrc;
        logic     regWrite;
        logic     isBranch;
        logic     illegal;
    } decodeBundle_t;

    // execute -> writeback and outputs
    typedef struct packed {
        logic     valid;
        regAddr_t rd;
        logic     regWrite;
        word_t    result;
        logic     zero;
        logic     eq;
        logic     less;
        logic     err;
    } execBundle_t;

endpackage

//--- logic/instrDecode.sv
`include "rvExec_settings.svh"

module instrDecode (
    input  logic                     clk,
    input  logic                     arstN,
    input  rvExecPkg::word_t         instr,
    input  logic                     instrValid,
    output rvExecPkg::decodeBundle_t decBus
);
    import rvExecPkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    word_t         immI;
    word_t         immU;
    word_t         immB;
    decodeBundle_t decNext;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immU = {instr[31:12], 12'b0};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        decNext       = '0;
        decNext.valid = instrValid;
        decNext.rs1   = instr[19:15];
        decNext.rs2   = instr[24:20];
        decNext.rd    = instr[11:7];
        decNext.wbSrc = ALU_RES;
        case (opcode)
            OPC_OP: begin
                decNext.regWrite = 1'b1;
                case (funct3)
                    3'b000: decNext.aluOp = funct7[5] ? SUB : ADD;
                    3'b001: decNext.aluOp = SLL;
                    3'b010: decNext.aluOp = SLT;
                    3'b011: decNext.aluOp = SLTU;
                    3'b100: decNext.aluOp = XOR;
                    3'b101: decNext.aluOp = funct7[5] ? SRA : SRL;
                    3'b110: decNext.aluOp = OR;
                    default: decNext.aluOp = AND;
                endcase
                // only SUB and SRA may carry the alternate funct7
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    decNext.illegal = 1'b1;
            end
            OPC_OPIMM: begin
                decNext.rs2      = '0;  // no second source
                decNext.useImm   = 1'b1;
                decNext.imm      = immI;
                decNext.regWrite = 1'b1;
                case (funct3)
                    3'b000: decNext.aluOp = ADD;
                    3'b001: begin
                        decNext.aluOp   = SLL;
                        decNext.illegal = (funct7 != 7'b0000000);
                    end
                    3'b010: decNext.aluOp = SLT;
                    3'b011: decNext.aluOp = SLTU;
                    3'b100: decNext.aluOp = XOR;
                    3'b101: begin
                        decNext.aluOp   = funct7[5] ? SRA : SRL;
                        decNext.illegal = ((funct7 & 7'b1011111) != 7'b0000000);
                    end
                    3'b110: decNext.aluOp = OR;
                    default: decNext.aluOp = AND;
                endcase
            end
            OPC_LUI: begin
                decNext.rs1      = '0;
                decNext.rs2      = '0;
                decNext.useImm   = 1'b1;
                decNext.imm      = immU;
                decNext.wbSrc    = IMM_RES;
                decNext.regWrite = 1'b1;
            end
            OPC_BRANCH: begin
                decNext.rd       = '0;  // branches write nothing
                decNext.imm      = immB;
                decNext.isBranch = 1'b1;
                case (funct3)
                    3'b000: decNext.aluOp = BEQ;
                    3'b001: decNext.aluOp = BNE;
                    3'b100: decNext.aluOp = BLT;
                    3'b101: decNext.aluOp = BGE;
                    3'b110: decNext.aluOp = BLTU;
                    3'b111: decNext.aluOp = BGEU;
                    default: decNext.illegal = 1'b1;
                endcase
            end
            default: decNext.illegal = 1'b1;  // loads, stores, jumps, system
        endcase
        if (decNext.illegal)
            decNext.regWrite = 1'b0;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decBus <= '0;
        end else begin
            decBus <= decNext;
        end
    end

    // a bundle flagged illegal must never request a register write downstream
    assert property (@(posedge clk) disable iff (!arstN)
        decBus.valid |-> !(decBus.illegal && decBus.regWrite));

endmodule

//--- logic/regFile.sv
`include "rvExec_settings.svh"

module regFile (
    input  logic                clk,
    input  logic                arstN,
    input  rvExecPkg::regAddr_t rdAddrA,
    input  rvExecPkg::regAddr_t rdAddrB,
    output rvExecPkg::word_t    rdDataA,
    output rvExecPkg::word_t    rdDataB,
    input  logic                wrEn,
    input  rvExecPkg::regAddr_t wrAddr,
    input  rvExecPkg::word_t    wrData,
    output rvExecPkg::word_t    regWindow [`NUM_REGS]
);
    import rvExecPkg::*;

    word_t regs [`NUM_REGS];
    logic  wrLive;  // write that actually lands

    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-first read ports
    assign rdDataA = (wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

    assign regWindow = regs;

    // x0 reads zero through storage and bypass alike
    assert property (@(posedge clk) disable iff (!arstN)
        regWindow[0] == '0 &&
        (rdAddrA != '0 || rdDataA == '0) &&
        (rdAddrB != '0 || rdDataB == '0));

endmodule

//--- logic/aluExecute.sv
`include "rvExec_settings.svh"

module aluExecute (
    input  logic                     clk,
    input  logic                     arstN,
    input  rvExecPkg::decodeBundle_t decBus,
    output rvExecPkg::regAddr_t      rdAddrA,
    output rvExecPkg::regAddr_t      rdAddrB,
    input  rvExecPkg::word_t         rdDataA,
    input  rvExecPkg::word_t         rdDataB,
    output rvExecPkg::execBundle_t   exeBus
);
    import rvExecPkg::*;

    logic        fwdA;
    logic        fwdB;
    word_t       opA;
    word_t       srcB;
    word_t       opB;
    word_t       aluRes;
    logic        eqRaw;
    logic        lessS;
    logic        lessU;
    logic        useUnsigned;
    execBundle_t exeNext;

    assign rdAddrA = decBus.rs1;
    assign rdAddrB = decBus.rs2;

    // bypass from the instruction one ahead, still sitting in exeBus
    assign fwdA = exeBus.valid && exeBus.regWrite && exeBus.rd != '0 &&
                  exeBus.rd == decBus.rs1;
    assign fwdB = exeBus.valid && exeBus.regWrite && exeBus.rd != '0 &&
                  exeBus.rd == decBus.rs2;

    assign opA  = fwdA ? exeBus.result : rdDataA;
    assign srcB = fwdB ? exeBus.result : rdDataB;
    assign opB  = decBus.useImm ? decBus.imm : srcB;

    assign eqRaw       = (opA == opB);
    assign lessS       = ($signed(opA) < $signed(opB));
    assign lessU       = (opA < opB);
    assign useUnsigned = decBus.aluOp inside {SLTU, BLTU, BGEU};

    always_comb begin
        case (decBus.aluOp)
            ADD:  aluRes = opA + opB;
            SUB:  aluRes = opA - opB;
            SLL:  aluRes = opA << opB[4:0];
            SLT:  aluRes = word_t'(lessS);
            SLTU: aluRes = word_t'(lessU);
            XOR:  aluRes = opA ^ opB;
            SRL:  aluRes = opA >> opB[4:0];
            SRA:  aluRes = word_t'($signed(opA) >>> opB[4:0]);
            OR:   aluRes = opA | opB;
            AND:  aluRes = opA & opB;
            BEQ:  aluRes = word_t'(eqRaw);   // taken = 1
            BNE:  aluRes = word_t'(!eqRaw);
            BLT:  aluRes = word_t'(lessS);
            BGE:  aluRes = word_t'(!lessS);
            BLTU: aluRes = word_t'(lessU);
            BGEU: aluRes = word_t'(!lessU);
            default: aluRes = '0;
        endcase
    end

    always_comb begin
        exeNext       = '0;
        exeNext.valid = decBus.valid;
        if (decBus.valid) begin
            exeNext.rd       = decBus.rd;
            exeNext.regWrite = decBus.regWrite && !decBus.isBranch && !decBus.illegal;
            if (decBus.illegal) begin
                exeNext.err = 1'b1;  // result stays 0
            end else begin
                exeNext.result = (decBus.wbSrc == IMM_RES) ? decBus.imm : aluRes;
                exeNext.eq     = eqRaw;
                exeNext.less   = useUnsigned ? lessU : lessS;
            end
            exeNext.zero = (exeNext.result == '0);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeBus <= '0;
        end else begin
            exeBus <= exeNext;
        end
    end

    // every result traces back to a valid decode one cycle earlier
    assert property (@(posedge clk) disable iff (!arstN)
        exeBus.valid |-> $past(decBus.valid));

endmodule

//--- logic/rvExecCore.sv
`include "rvExec_settings.svh"

module rvExecCore (
    input  logic                clk,
    input  logic                arstN,
    input  rvExecPkg::word_t    instr,
    input  logic                instrValid,
    output rvExecPkg::word_t    result,
    output rvExecPkg::regAddr_t rd,
    output logic                resultValid,
    output logic                zeroFlag,
    output logic                eqFlag,
    output logic                lessFlag,
    output logic                errFlag,
    output rvExecPkg::word_t    regWindow [`NUM_REGS]
);
    import rvExecPkg::*;

    decodeBundle_t decBus;
    execBundle_t   exeBus;
    regAddr_t      rdAddrA;
    regAddr_t      rdAddrB;
    word_t         rdDataA;
    word_t         rdDataB;
    logic          wrEn;

    instrDecode uDecode (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .decBus     (decBus)
    );

    aluExecute uExecute (
        .clk     (clk),
        .arstN   (arstN),
        .decBus  (decBus),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .exeBus  (exeBus)
    );

    // writeback straight from the execute register
    assign wrEn = exeBus.valid && exeBus.regWrite && (exeBus.rd != '0);

    regFile uRegs (
        .clk       (clk),
        .arstN     (arstN),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .wrEn      (wrEn),
        .wrAddr    (exeBus.rd),
        .wrData    (exeBus.result),
        .regWindow (regWindow)
    );

    assign result      = exeBus.result;
    assign rd          = exeBus.rd;
    assign resultValid = exeBus.valid;
    assign zeroFlag    = exeBus.zero;
    assign eqFlag      = exeBus.eq;
    assign lessFlag    = exeBus.less;
    assign errFlag     = exeBus.err;

endmodule

//--- sim/rvExecChecker.sv
`include "rvExec_settings.svh"

module rvExecChecker (
    input  logic                clk,
    input  logic                expPush,
    input  logic [127:0]        expName,
    input  rvExecPkg::word_t    expInstr,
    input  rvExecPkg::word_t    expResult,
    input  logic [3:0]          expFlags,
    input  logic                resetCheck,
    input  logic                finalCheck,
    input  rvExecPkg::word_t    expRegs [`NUM_REGS],
    input  rvExecPkg::word_t    result,
    input  rvExecPkg::regAddr_t rd,
    input  logic                resultValid,
    input  logic                zeroFlag,
    input  logic                eqFlag,
    input  logic                lessFlag,
    input  logic                errFlag,
    input  rvExecPkg::word_t    regWindow [`NUM_REGS],
    output int                  mismatches,
    output int                  otherErrors
);
    timeunit 1ns;
    timeprecision 1ps;
    import rvExecPkg::*;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        logic [127:0] name;
        word_t        instr;
        word_t        result;
        logic [3:0]   flags;
    } expect_t;

    expect_t    pending [$];  // oldest instruction first
    expect_t    entry;
    expect_t    head;
    regAddr_t   wantRd;
    logic [3:0] actFlags;
    int         valueErrors = 0;
    int         plainErrors = 0;

    assign actFlags    = {zeroFlag, eqFlag, lessFlag, errFlag};
    assign mismatches  = valueErrors;
    assign otherErrors = plainErrors;

    // falling edge, outputs settled since the rising edge
    always @(negedge clk) begin
        if (expPush) begin
            entry.name   = expName;
            entry.instr  = expInstr;
            entry.result = expResult;
            entry.flags  = expFlags;
            pending.push_back(entry);
        end
        if (resultValid) begin
            if (pending.size() == 0) begin
                $display("result %08h came out with no instruction outstanding", result);
                plainErrors++;
            end else begin
                head = pending.pop_front();
                if (result !== head.result) begin
                    $display("[FAIL] %0s result: expected %08h, actual %08h",
                             head.name, head.result, result);
                    valueErrors++;
                end
                if (actFlags !== head.flags) begin
                    $display("[FAIL] %0s flags: expected %h, actual %h",
                             head.name, head.flags, actFlags);
                    valueErrors++;
                end
                // legal non-branch ops name their destination in bits 11:7
                if (!head.flags[0] && head.instr[6:0] != OPC_BRANCH) begin
                    wantRd = head.instr[11:7];
                    if (rd !== wantRd) begin
                        $display("[FAIL] %0s rd: expected x%0d, actual x%0d",
                                 head.name, wantRd, rd);
                        valueErrors++;
                    end
                end
            end
        end
        if (resetCheck) begin
            if ({resultValid, actFlags} !== 5'b0) begin
                $display("[FAIL] reset outputs: expected %h, actual %h",
                         5'b0, {resultValid, actFlags});
                valueErrors++;
            end
            foreach (regWindow[i]) begin
                if (regWindow[i] !== '0) begin
                    $display("[FAIL] reset x%0d: expected %08h, actual %08h",
                             i, 32'h0, regWindow[i]);
                    valueErrors++;
                end
            end
        end
        if (finalCheck) begin
            foreach (regWindow[i]) begin
                if (regWindow[i] !== expRegs[i]) begin
                    $display("[FAIL] final x%0d: expected %08h, actual %08h",
                             i, expRegs[i], regWindow[i]);
                    valueErrors++;
                end
            end
            if (pending.size() != 0) begin
                $display("%0d expected results never came out", pending.size());
                plainErrors++;
            end
        end
    end

endmodule

//--- sim/rvExecCoreTb.sv
`include "rvExec_settings.svh"

module rvExecCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import rvExecPkg::*;

    localparam logic [127:0] REGS_TAG    = "regs";
    localparam logic [127:0] COMMENT_TAG = "#";

    typedef struct packed {
        logic [127:0] name;
        word_t        instr;
        word_t        result;
        logic [3:0]   flags;  // zero, eq, less, err
    } vector_t;

    logic         clk = 1'b0;
    logic         arstN;
    word_t        instr;
    logic         instrValid;
    word_t        result;
    regAddr_t     rd;
    logic         resultValid;
    logic         zeroFlag;
    logic         eqFlag;
    logic         lessFlag;
    logic         errFlag;
    word_t        regWindow [`NUM_REGS];

    logic         expPush;
    logic [127:0] expName;
    word_t        expInstr;
    word_t        expResult;
    logic [3:0]   expFlags;
    logic         resetCheck;
    logic         finalCheck;
    word_t        expRegs [`NUM_REGS];
    int           mismatches;
    int           otherErrors;

    vector_t      vectors [$];
    int           idleAfter [$];
    int           loadErrors = 0;
    int           budgetCycles = 0;
    logic         loadDone = 1'b0;

    always #5 clk = ~clk;

    rvExecCore UUT (
        .clk         (clk),
        .arstN       (arstN),
        .instr       (instr),
        .instrValid  (instrValid),
        .result      (result),
        .rd          (rd),
        .resultValid (resultValid),
        .zeroFlag    (zeroFlag),
        .eqFlag      (eqFlag),
        .lessFlag    (lessFlag),
        .errFlag     (errFlag),
        .regWindow   (regWindow)
    );

    rvExecChecker uChecker (
        .clk         (clk),
        .expPush     (expPush),
        .expName     (expName),
        .expInstr    (expInstr),
        .expResult   (expResult),
        .expFlags    (expFlags),
        .resetCheck  (resetCheck),
        .finalCheck  (finalCheck),
        .expRegs     (expRegs),
        .result      (result),
        .rd          (rd),
        .resultValid (resultValid),
        .zeroFlag    (zeroFlag),
        .eqFlag      (eqFlag),
        .lessFlag    (lessFlag),
        .errFlag     (errFlag),
        .regWindow   (regWindow),
        .mismatches  (mismatches),
        .otherErrors (otherErrors)
    );

    // lines are either comments, vectors or a block of eight final register values
    task automatic loadVectors();
        int           fd;
        int           code;
        int           ch;
        int           base;
        int           idle;
        logic [127:0] tok;
        word_t        vInstr;
        word_t        vResult;
        logic [3:0]   vFlags;
        word_t        regVal;
        vector_t      vec;
        fd = $fopen("sim/rvExecVectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/rvExecVectors.txt");
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == COMMENT_TAG) begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);  // rest of the comment line
            end else if (tok == REGS_TAG) begin
                code = $fscanf(fd, "%d", base);
                for (int i = 0; i < 8; i++) begin
                    code = $fscanf(fd, "%h", regVal);
                    if (code == 1 && base + i < `NUM_REGS)
                        expRegs[base + i] = regVal;
                end
            end else begin
                code = $fscanf(fd, "%h %h %h %d", vInstr, vResult, vFlags, idle);
                if (code != 4) begin
                    $display("vector %0s is malformed and was skipped", tok);
                    loadErrors++;
                end else begin
                    vec.name   = tok;
                    vec.instr  = vInstr;
                    vec.result = vResult;
                    vec.flags  = vFlags;
                    vectors.push_back(vec);
                    idleAfter.push_back(idle);
                end
            end
        end
        $fclose(fd);
    endtask

    // one instruction on the falling edge, then optional bubbles
    task automatic applyVector(input vector_t vec, input int idle);
        @(negedge clk);
        instr      <= vec.instr;
        instrValid <= 1'b1;
        expPush    <= 1'b1;
        expName    <= vec.name;
        expInstr   <= vec.instr;
        expResult  <= vec.result;
        expFlags   <= vec.flags;
        repeat (idle) begin
            @(negedge clk);
            instrValid <= 1'b0;
            expPush    <= 1'b0;
        end
    endtask

    initial begin
        arstN      <= 1'b0;
        instr      <= '0;
        instrValid <= 1'b0;
        expPush    <= 1'b0;
        expName    <= '0;
        expInstr   <= '0;
        expResult  <= '0;
        expFlags   <= '0;
        resetCheck <= 1'b0;
        finalCheck <= 1'b0;
        foreach (expRegs[i])
            expRegs[i] = '0;
        loadVectors();
        if (vectors.size() == 0) begin
            $display("no vectors were loaded");
            loadErrors++;
        end
        budgetCycles = vectors.size() + 20;
        foreach (idleAfter[i])
            budgetCycles += idleAfter[i];
        loadDone = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN      <= 1'b1;
        resetCheck <= 1'b1;  // everything should still read zero
        @(negedge clk);
        resetCheck <= 1'b0;
        foreach (vectors[i])
            applyVector(vectors[i], idleAfter[i]);
        @(negedge clk);
        instrValid <= 1'b0;
        expPush    <= 1'b0;
        repeat (3) @(negedge clk);  // let the last writeback land
        finalCheck <= 1'b1;
        @(negedge clk);
        finalCheck <= 1'b0;
        @(negedge clk);
        $display("errors: %0d value mismatches, %0d other failures, %0d load problems",
                 mismatches, otherErrors, loadErrors);
        if (mismatches + otherErrors + loadErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // budget covers every vector, every bubble and some slack for reset and drain
    initial begin
        wait (loadDone);
        #(budgetCycles * 10);
        $display("timeout after %0d cycles, the run never reached its end", budgetCycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- sim/rvExecVectors.txt
# name instr result flags(zero,eq,less,err) idleCyclesAfter, all hex except idle
# regs firstIndex then eight expected final register values
addi_x1_5      00500093 00000005 2 0
addi_x2_neg3   ffd00113 fffffffd 0 0
lui_x3_msb     800001b7 80000000 0 0
lui_x4         12345237 12345000 2 0
addi_x4_fwd    67820213 12345678 0 2
add_x5         002082b3 00000002 0 0
sub_x6_fwd     40128333 fffffffd 2 0
xor_x7_fwd     005343b3 ffffffff 2 0
and_x8_fwd     0043f433 12345678 2 0
or_x9_fwd      001464b3 1234567d 0 0
add_x9_self    009484b3 2468acfa 4 0
srai_x10       4041d513 f8000000 2 0
srli_x11       0041d593 08000000 2 0
sra_x12        4011d633 fc000000 2 0
srl_x13        0011d6b3 04000000 2 0
slt_x14_msb    0011a733 00000001 2 0
sltu_x15_msb   0011b7b3 00000000 8 0
sll_x16        00109833 000000a0 4 0
sltiu_x17      fff13893 00000001 2 0
slti_x18       fff12913 00000001 2 1
beq_taken      00108463 00000001 4 0
bne_taken      00209463 00000001 0 0
blt_taken      00114463 00000001 2 0
bge_not_taken  00115463 00000000 a 0
bltu_not_taken 00116463 00000000 8 0
bgeu_taken     00117463 00000001 0 0
lw_illegal     0000a983 00000000 9 0
sw_illegal     00112023 00000000 9 0
jal_illegal    00800a6f 00000000 9 0
addi_x0_drop   00708013 0000000c 2 0
add_x21_x0     00100ab3 00000005 2 0
mul_illegal    02108b33 00000000 9 0
regs 0  00000000 00000005 fffffffd 80000000 12345678 00000002 fffffffd ffffffff
regs 8  12345678 2468acfa f8000000 08000000 fc000000 04000000 00000001 00000000
regs 16 000000a0 00000001 00000001 00000000 00000000 00000005 00000000 00000000
regs 24 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- verilog.f
+incdir+logic
logic/rvExecPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/rvExecCore.sv
sim/rvExecChecker.sv
sim/rvExecCoreTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module rvExecCoreTb -Mdir obj_dir

output="$(./obj_dir/VrvExecCoreTb)"
echo "$output"

# pass only when the testbench printed its pass line
grep -qx "Test OK" <<< "$output"
